//--- boundary_apb_regs.sv
// boundary_apb_regs: APB slave with control, status, result and run-count registers
`timescale 1ns/1ps
`include "qec_boundary_cfg.svh"

module boundary_apb_regs (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  qec_boundary_pkg::apb_addr_t        paddr,
    input  qec_boundary_pkg::apb_data_t        pwdata,
    output qec_boundary_pkg::apb_data_t        prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  qec_boundary_pkg::boundary_result_t result,
    input  logic                               done,
    output logic                               start
);

    logic access;
    logic addr_ok;
    logic accept;
    logic busy;
    logic done_flag;

    // second phase of a transfer
    assign access = psel && penable;

    always_comb begin
        case (paddr)
            `QEC_REG_CTRL, `QEC_REG_STATUS, `QEC_REG_RESULT, `QEC_REG_RUNS: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    // no wait states
    assign pready = 1'b1;
    assign pslverr = access && !addr_ok;

    // run request on CTRL bit 0, dropped while a run is in flight
    assign accept = access && pwrite && (paddr == `QEC_REG_CTRL) && pwdata[0] && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            start <= 1'b0;
            busy <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            // start follows the access cycle by one clock
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
                done_flag <= 1'b0;
            end else if (done) begin
                busy <= 1'b0;
                done_flag <= 1'b1;
            end
        end
    end

    // read mux, zero outside read access cycles
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                `QEC_REG_STATUS: prdata = {30'd0, done_flag, busy};
                `QEC_REG_RESULT: prdata = {30'd0, result.z_parity, result.x_parity};
                `QEC_REG_RUNS:   prdata = qec_boundary_pkg::apb_data_t'(result.runs);
                // CTRL reads back as zero
                default:         prdata = '0;
            endcase
        end
    end

endmodule

//--- boundary_cardinality_scanner.sv
// boundary_cardinality_scanner: walks one boundary face and XORs the odd flags of its roots
`timescale 1ns/1ps
`include "qec_boundary_cfg.svh"

module boundary_cardinality_scanner #(
    // 0 walks the x face (column zero), 1 the z face (last column)
    parameter int BOUNDARY_TYPE = 0
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  qec_boundary_pkg::grid_view_t grid,
    output qec_boundary_pkg::face_result_t result
);

    localparam int WALK_LEN = `QEC_BOUNDARY_PU_COUNT;
    localparam int STEP_W = $clog2(WALK_LEN);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(WALK_LEN - 1);
    // column held fixed for the whole walk
    localparam int J_FACE = (BOUNDARY_TYPE == 0) ? 0 : `QEC_DIST_Z - 1;

    qec_boundary_pkg::scan_state_t state;
    logic [STEP_W-1:0] step;

    // face coordinates of the current step
    qec_boundary_pkg::pu_index_t walk_i;
    qec_boundary_pkg::pu_index_t walk_k;
    qec_boundary_pkg::pu_index_t walk_pu;

    // PU registered during the walk, examined one cycle later
    qec_boundary_pkg::pu_index_t cur_pu;
    logic cur_valid;
    qec_boundary_pkg::pu_index_t cur_root;

    // bit r holds the odd flag of root r once r has been reached
    qec_boundary_pkg::pu_mask_t marked;

    // i is the inner loop, k the outer loop
    always_comb begin
        walk_i = qec_boundary_pkg::pu_index_t'(step % `QEC_DIST_X);
        walk_k = qec_boundary_pkg::pu_index_t'(step / `QEC_DIST_X);
        walk_pu = qec_boundary_pkg::pu_index_t'(`QEC_PU_INDEX(walk_i, J_FACE, walk_k));
    end

    // root slice of the registered PU
    assign cur_root = grid.roots[cur_pu*`QEC_PU_IDX_W +: `QEC_PU_IDX_W];

    // walk FSM, one face PU per cycle then drain and done
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= qec_boundary_pkg::SCAN_IDLE;
            step <= '0;
        end else begin
            case (state)
                qec_boundary_pkg::SCAN_IDLE: begin
                    step <= '0;
                    if (start) begin
                        state <= qec_boundary_pkg::SCAN_WALK;
                    end
                end
                qec_boundary_pkg::SCAN_WALK: begin
                    step <= step + 1'b1;
                    if (step == LAST_STEP) begin
                        state <= qec_boundary_pkg::SCAN_DRAIN;
                    end
                end
                // last PU gets marked here
                qec_boundary_pkg::SCAN_DRAIN: begin
                    state <= qec_boundary_pkg::SCAN_DONE;
                end
                default: begin
                    state <= qec_boundary_pkg::SCAN_IDLE;
                end
            endcase
        end
    end

    // index pipeline stage
    always_ff @(posedge clk) begin
        if (reset) begin
            cur_valid <= 1'b0;
        end else begin
            cur_valid <= (state == qec_boundary_pkg::SCAN_WALK);
        end
        cur_pu <= walk_pu;
    end

    // marking stage, a root reached twice is simply rewritten with the same flag
    always_ff @(posedge clk) begin
        if (reset) begin
            marked <= '0;
        end else if (start) begin
            marked <= '0;
        end else if (cur_valid && grid.touching[cur_pu]) begin
            marked[cur_root] <= grid.odd[cur_root];
        end
    end

    // marked set is final once the drain cycle is over
    assign result.valid = (state == qec_boundary_pkg::SCAN_DONE);
    assign result.parity = ^marked;

endmodule

//--- boundary_parity_props.sv
// boundary_parity_props: start width, pslverr phase and scanner valid checks, bound to the top level
`timescale 1ns/1ps

module boundary_parity_props (
    input logic                           clk,
    input logic                           reset,
    input logic                           psel,
    input logic                           penable,
    input logic                           pslverr,
    input logic                           start,
    input qec_boundary_pkg::face_result_t x_face,
    input qec_boundary_pkg::face_result_t z_face
);

    // set by start, cleared by that face's valid pulse
    logic x_armed;
    logic z_armed;

    always_ff @(posedge clk) begin
        if (reset) begin
            x_armed <= 1'b0;
            z_armed <= 1'b0;
        end else begin
            if (start) begin
                x_armed <= 1'b1;
                z_armed <= 1'b1;
            end else begin
                if (x_face.valid) begin
                    x_armed <= 1'b0;
                end
                if (z_face.valid) begin
                    z_armed <= 1'b0;
                end
            end
        end
    end

    start_one_cycle: assert property (@(posedge clk) disable iff (reset) start |=> !start)
        else $error("start held high for more than one cycle");

    pslverr_in_access: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> (psel && penable))
        else $error("pslverr raised outside an access cycle");

    x_valid_after_start: assert property (@(posedge clk) disable iff (reset)
        x_face.valid |-> x_armed)
        else $error("x scanner valid without a preceding start");

    z_valid_after_start: assert property (@(posedge clk) disable iff (reset)
        z_face.valid |-> z_armed)
        else $error("z scanner valid without a preceding start");

endmodule

bind boundary_parity_top boundary_parity_props i_boundary_parity_props (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pslverr (pslverr),
    .start   (start),
    .x_face  (x_face),
    .z_face  (z_face)
);

//--- boundary_parity_tb.sv
// clock, reset, APB tasks, reference model, compare tasks and directed tests for the parity unit
`timescale 1ns/1ps
`include "qec_boundary_cfg.svh"

module boundary_parity_tb;

    // 8 runs of about 20 cycles each, plus reset and register accesses
    localparam int TIMEOUT_CYCLES = 8 * 20 + 200;
    localparam int IDX_W = `QEC_PU_IDX_W;

    logic clk;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    qec_boundary_pkg::apb_addr_t paddr;
    qec_boundary_pkg::apb_data_t pwdata;
    qec_boundary_pkg::apb_data_t prdata;
    logic pready;
    logic pslverr;
    qec_boundary_pkg::grid_view_t grid;

    integer seed;
    int cycles;
    // RUNS as it should read after the last completed run
    qec_boundary_pkg::run_count_t exp_runs;

    boundary_parity_top i_boundary_parity_top (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .grid    (grid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run(input string what);
        $display("Simulation finished: FAIL");
        $fatal(1, what);
    endtask

    // cycle counter that ends a hung run
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        stop_run("timeout");
    end

    task automatic compare_parity(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %0b, actual %0b", name, expected, actual);
            stop_run("parity mismatch");
        end
    endtask

    task automatic compare_data(input string name, input qec_boundary_pkg::apb_data_t expected,
                                input qec_boundary_pkg::apb_data_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
            stop_run("register mismatch");
        end
    endtask

    task automatic compare_runs(input string name, input qec_boundary_pkg::run_count_t expected,
                                input qec_boundary_pkg::run_count_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            stop_run("run count mismatch");
        end
    endtask

    // setup cycle, access cycle, then bus back to idle
    task automatic apb_write(input qec_boundary_pkg::apb_addr_t addr,
                             input qec_boundary_pkg::apb_data_t data);
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;
        compare_data("apb write pready", 32'h1, qec_boundary_pkg::apb_data_t'(pready));
        compare_data("apb write pslverr", 32'h0, qec_boundary_pkg::apb_data_t'(pslverr));
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    // prdata, pready and pslverr taken mid access cycle
    task automatic apb_read(input string name, input qec_boundary_pkg::apb_addr_t addr,
                            input logic exp_err, output qec_boundary_pkg::apb_data_t data);
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;
        data = prdata;
        compare_data({name, " pready"}, 32'h1, qec_boundary_pkg::apb_data_t'(pready));
        compare_data({name, " pslverr"}, qec_boundary_pkg::apb_data_t'(exp_err),
                     qec_boundary_pkg::apb_data_t'(pslverr));
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    function automatic int pu_at(input int i, input int j, input int k);
        return i * `QEC_DIST_Z + j + k * `QEC_DIST_Z * `QEC_DIST_X;
    endfunction

    // reference model XORs the odd flags of the roots of touching face PUs, each root once
    function automatic logic face_parity(input qec_boundary_pkg::grid_view_t g, input int j);
        qec_boundary_pkg::pu_mask_t seen;
        logic par;
        int pu;
        int root;
        seen = '0;
        par = 1'b0;
        for (int k = 0; k < `QEC_ROUNDS; k++) begin
            for (int i = 0; i < `QEC_DIST_X; i++) begin
                pu = pu_at(i, j, k);
                if (g.touching[pu]) begin
                    root = g.roots[pu*IDX_W +: IDX_W];
                    if (!seen[root]) begin
                        seen[root] = 1'b1;
                        par ^= g.odd[root];
                    end
                end
            end
        end
        return par;
    endfunction

    // poll STATUS until done and expect busy low by then
    task automatic wait_done(input string name);
        qec_boundary_pkg::apb_data_t status;
        status = '0;
        while (!status[1]) begin
            apb_read({name, " poll"}, `QEC_REG_STATUS, 1'b0, status);
        end
        compare_data({name, " status"}, 32'h2, status);
    endtask

    task automatic run_grid(input string name, input qec_boundary_pkg::grid_view_t g,
                            input logic exp_x, input logic exp_z);
        qec_boundary_pkg::apb_data_t data;
        @(posedge clk);
        #1;
        grid = g;
        apb_write(`QEC_REG_CTRL, 32'h1);
        wait_done(name);
        exp_runs++;
        apb_read(name, `QEC_REG_RESULT, 1'b0, data);
        compare_parity({name, " x parity"}, exp_x, data[0]);
        compare_parity({name, " z parity"}, exp_z, data[1]);
        apb_read(name, `QEC_REG_RUNS, 1'b0, data);
        compare_runs({name, " runs"}, exp_runs, qec_boundary_pkg::run_count_t'(data));
    endtask

    task automatic test_reset_values();
        qec_boundary_pkg::apb_data_t data;
        apb_read("reset status", `QEC_REG_STATUS, 1'b0, data);
        compare_data("reset status", 32'h0, data);
        apb_read("reset result", `QEC_REG_RESULT, 1'b0, data);
        compare_data("reset result", 32'h0, data);
        apb_read("reset runs", `QEC_REG_RUNS, 1'b0, data);
        compare_data("reset runs", 32'h0, data);
    endtask

    // one touching x face PU that is its own odd root
    task automatic test_single_odd();
        qec_boundary_pkg::grid_view_t g;
        int pu;
        g = '0;
        pu = pu_at(1, 0, 0);
        g.touching[pu] = 1'b1;
        g.odd[pu] = 1'b1;
        g.roots[pu*IDX_W +: IDX_W] = IDX_W'(pu);
        run_grid("single_odd", g, 1'b1, 1'b0);
    endtask

    // two x face PUs under one interior odd root, one z face PU under another
    task automatic test_shared_root();
        qec_boundary_pkg::grid_view_t g;
        int x_root;
        int z_root;
        g = '0;
        x_root = pu_at(1, 1, 0);
        z_root = pu_at(1, 1, 2);
        g.odd[x_root] = 1'b1;
        g.odd[z_root] = 1'b1;
        g.touching[pu_at(0, 0, 0)] = 1'b1;
        g.touching[pu_at(2, 0, 1)] = 1'b1;
        g.touching[pu_at(1, 2, 2)] = 1'b1;
        g.roots[pu_at(0, 0, 0)*IDX_W +: IDX_W] = IDX_W'(x_root);
        g.roots[pu_at(2, 0, 1)*IDX_W +: IDX_W] = IDX_W'(x_root);
        g.roots[pu_at(1, 2, 2)*IDX_W +: IDX_W] = IDX_W'(z_root);
        run_grid("shared_root", g, 1'b1, 1'b1);
    endtask

    task automatic test_random_grids();
        qec_boundary_pkg::grid_view_t g;
        for (int n = 0; n < 5; n++) begin
            g.odd = qec_boundary_pkg::pu_mask_t'($random(seed));
            g.touching = qec_boundary_pkg::pu_mask_t'($random(seed));
            // roots stay inside the grid
            for (int p = 0; p < `QEC_PU_COUNT; p++) begin
                g.roots[p*IDX_W +: IDX_W] =
                    IDX_W'(($random(seed) & 32'h7fff_ffff) % `QEC_PU_COUNT);
            end
            run_grid($sformatf("random_%0d", n), g, face_parity(g, 0),
                     face_parity(g, `QEC_DIST_Z - 1));
        end
    endtask

    task automatic test_addr_busy();
        qec_boundary_pkg::apb_data_t data;
        apb_read("bad_address", 4'h6, 1'b1, data);
        // done is still set from the last random run and a new start clears it
        apb_write(`QEC_REG_CTRL, 32'h1);
        apb_read("new_start", `QEC_REG_STATUS, 1'b0, data);
        compare_data("new_start status", 32'h1, data);
        // second request lands while busy and is dropped
        apb_write(`QEC_REG_CTRL, 32'h1);
        wait_done("busy_write");
        exp_runs++;
        // the walk of the current grid runs on undisturbed
        apb_read("busy_write", `QEC_REG_RESULT, 1'b0, data);
        compare_parity("busy_write x parity", face_parity(grid, 0), data[0]);
        compare_parity("busy_write z parity", face_parity(grid, `QEC_DIST_Z - 1), data[1]);
        apb_read("busy_write", `QEC_REG_RUNS, 1'b0, data);
        compare_runs("busy_write runs", exp_runs, qec_boundary_pkg::run_count_t'(data));
    endtask

    initial begin
        seed = 32'hae03_7c13;
        exp_runs = '0;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        grid = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_values();
        test_single_odd();
        test_shared_root();
        test_random_grids();
        test_addr_busy();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- boundary_parity_top.sv
// boundary_parity_top: register block, x and z face scanners and parity combiner
`timescale 1ns/1ps

module boundary_parity_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  qec_boundary_pkg::apb_addr_t  paddr,
    input  qec_boundary_pkg::apb_data_t  pwdata,
    output qec_boundary_pkg::apb_data_t  prdata,
    output logic                         pready,
    output logic                         pslverr,
    // must hold still from start to done
    input  qec_boundary_pkg::grid_view_t grid
);

    logic start;
    logic done;
    qec_boundary_pkg::face_result_t x_face;
    qec_boundary_pkg::face_result_t z_face;
    qec_boundary_pkg::boundary_result_t result;

    boundary_apb_regs i_boundary_apb_regs (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .result  (result),
        .done    (done),
        .start   (start)
    );

    // column zero face
    boundary_cardinality_scanner #(
        .BOUNDARY_TYPE (0)
    ) i_x_scanner (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .grid   (grid),
        .result (x_face)
    );

    // last column face
    boundary_cardinality_scanner #(
        .BOUNDARY_TYPE (1)
    ) i_z_scanner (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .grid   (grid),
        .result (z_face)
    );

    parity_combiner i_parity_combiner (
        .clk    (clk),
        .reset  (reset),
        .x_face (x_face),
        .z_face (z_face),
        .result (result),
        .done   (done)
    );

endmodule

//--- compile.f
+incdir+.
qec_boundary_pkg.sv
boundary_cardinality_scanner.sv
parity_combiner.sv
boundary_apb_regs.sv
boundary_parity_top.sv
boundary_parity_props.sv
boundary_parity_tb.sv

//--- parity_combiner.sv
// parity_combiner: joins the two face parities, counts runs and pulses done
`timescale 1ns/1ps

module parity_combiner (
    input  logic                               clk,
    input  logic                               reset,
    input  qec_boundary_pkg::face_result_t     x_face,
    input  qec_boundary_pkg::face_result_t     z_face,
    output qec_boundary_pkg::boundary_result_t result,
    output logic                               done
);

    // face already reported in an earlier cycle
    logic x_pend;
    logic z_pend;
    logic x_par;
    logic z_par;

    // face reported now or earlier
    logic x_ready;
    logic z_ready;
    logic x_par_now;
    logic z_par_now;

    assign x_ready = x_pend | x_face.valid;
    assign z_ready = z_pend | z_face.valid;
    // a pulse in this cycle takes precedence over the held copy
    assign x_par_now = x_face.valid ? x_face.parity : x_par;
    assign z_par_now = z_face.valid ? z_face.parity : z_par;

    always_ff @(posedge clk) begin
        if (reset) begin
            x_pend <= 1'b0;
            z_pend <= 1'b0;
            result <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (x_face.valid) begin
                x_pend <= 1'b1;
            end
            if (z_face.valid) begin
                z_pend <= 1'b1;
            end
            // both faces in, in either order
            if (x_ready && z_ready) begin
                result.x_parity <= x_par_now;
                result.z_parity <= z_par_now;
                result.runs <= result.runs + 1'b1;
                x_pend <= 1'b0;
                z_pend <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // held parities
    always_ff @(posedge clk) begin
        x_par <= x_par_now;
        z_par <= z_par_now;
    end

endmodule

//--- qec_boundary_cfg.svh
// code distances, rounds, derived PU counts, PU index formula and APB register offsets
`ifndef QEC_BOUNDARY_CFG_SVH
`define QEC_BOUNDARY_CFG_SVH

// code distances
`define QEC_DIST_X 3
`define QEC_DIST_Z 3

// measurement rounds follow the larger distance
`define QEC_ROUNDS (((`QEC_DIST_X) > (`QEC_DIST_Z)) ? (`QEC_DIST_X) : (`QEC_DIST_Z))

// whole grid and one boundary face
`define QEC_PU_COUNT ((`QEC_DIST_X) * (`QEC_DIST_Z) * (`QEC_ROUNDS))
`define QEC_BOUNDARY_PU_COUNT ((`QEC_DIST_X) * (`QEC_ROUNDS))
`define QEC_PU_IDX_W $clog2(`QEC_PU_COUNT)

// flat index, j runs fastest, then i, then the round k
`define QEC_PU_INDEX(i, j, k) ((i) * (`QEC_DIST_Z) + (j) + (k) * (`QEC_DIST_Z) * (`QEC_DIST_X))

// APB byte offsets
`define QEC_REG_CTRL   4'h0
`define QEC_REG_STATUS 4'h4
`define QEC_REG_RESULT 4'h8
`define QEC_REG_RUNS   4'hC

`endif

//--- qec_boundary_pkg.sv
// vector typedefs, scanner state enum and shared structs for the boundary parity unit
`include "qec_boundary_cfg.svh"

package qec_boundary_pkg;

    // flat index of one processing unit
    typedef logic [`QEC_PU_IDX_W-1:0] pu_index_t;

    // one flag bit per processing unit
    typedef logic [`QEC_PU_COUNT-1:0] pu_mask_t;

    // root index of every PU, PU 0 in the lowest slice
    typedef logic [`QEC_PU_COUNT*`QEC_PU_IDX_W-1:0] root_map_t;

    // completed-run counter
    typedef logic [15:0] run_count_t;

    // APB data and byte address
    typedef logic [31:0] apb_data_t;
    typedef logic [3:0] apb_addr_t;

    // boundary scanner states
    typedef enum logic [1:0] {
        SCAN_IDLE  = 2'd0,
        SCAN_WALK  = 2'd1,
        SCAN_DRAIN = 2'd2,
        SCAN_DONE  = 2'd3
    } scan_state_t;

    // decoder grid after cluster growth, as the scanners see it
    typedef struct packed {
        pu_mask_t  odd;
        pu_mask_t  touching;
        root_map_t roots;
    } grid_view_t;

    // one face parity, valid for a single cycle
    typedef struct packed {
        logic valid;
        logic parity;
    } face_result_t;

    // registered outcome of the last completed run
    typedef struct packed {
        logic       x_parity;
        logic       z_parity;
        run_count_t runs;
    } boundary_result_t;

endpackage
